//--- run_sim.sh
#!/usr/bin/env bash
# build and run the multiplier testbench with Verilator

set -u

cd "$(dirname "$0")" || exit 1

TOP=tb_seq_multiplier
BUILD_DIR=obj_dir
BUILD_LOG=build.log
SIM_LOG=sim.log

# compile
verilator --binary --timing \
    -f sources.f \
    --top-module "$TOP" \
    --Mdir "$BUILD_DIR" \
    -o "$TOP" > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "verilator build failed"
    exit 1
fi

# run
"./$BUILD_DIR/$TOP" > "$SIM_LOG" 2>&1
run_status=$?
cat "$SIM_LOG"
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

# verdict comes from the log
if grep -q "SOME TESTS FAILED" "$SIM_LOG"; then
    exit 1
fi

exit 0

//--- sim/tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// error counters per kind of result
int err_product = 0;
int err_status  = 0;
int err_timing  = 0;

task automatic check_product(input product_t got, input product_t exp, input string what);
    if (got !== exp) begin
        $display("ERROR %0t ns: %s product 0x%04h, expected 0x%04h", $time, what, got, exp);
        err_product++;
    end
endtask

task automatic check_state(input state_e got, input state_e exp, input string what);
    if (got !== exp) begin
        $display("ERROR %0t ns: %s state %s, expected %s", $time, what, got.name(),
                 exp.name());
        err_status++;
    end
endtask

// o_rdy level
task automatic check_rdy(input logic got, input logic exp, input string what);
    if (got !== exp) begin
        $display("ERROR %0t ns: %s o_rdy %b, expected %b", $time, what, got, exp);
        err_status++;
    end
endtask

// cycles from the start edge to the rise of o_rdy
task automatic check_latency(input int got, input int exp, input string what);
    if (got != exp) begin
        $display("ERROR %0t ns: %s %0d cycles, expected %0d", $time, what, got, exp);
        err_timing++;
    end
endtask

`endif

//--- sim/tb_seq_multiplier.sv
`timescale 1ns/10ps

module tb_seq_multiplier;

    import definitions_pkg::*;

    localparam int CLK_PERIOD     = 4;
    localparam int STIM_DELAY     = 1;     // after the rising edge
    localparam int RESET_CYCLES   = 5;
    localparam int RDY_LATENCY    = 8;     // start edge to the rise of o_rdy
    localparam int N_CORNER       = 5;
    localparam int N_RANDOM       = 200;
    localparam int HOLD_CYCLES    = 20;
    localparam int N_TESTS        = N_CORNER + N_RANDOM + 2;  // plus stray start and hold
    localparam int TIMEOUT_CYCLES = N_TESTS * 20 + 100;

    logic     clk;
    logic     rst;
    logic     i_start;
    mul_req_t i_req;
    product_t o_product;
    logic     o_rdy;
    state_e   o_state;

    integer   seed = 32'h61d30812;
    int       cycle_cnt = 0;       // rising edges seen so far
    int       issued = 0;
    int       checked = 0;
    product_t exp_q[$];            // expected products in start order
    int       start_q[$];          // edge number of each accepted start

    `include "tb_checks.svh"

    seq_multiplier seq_multiplier_i (
        .clk       (clk),
        .rst       (rst),
        .i_start   (i_start),
        .i_req     (i_req),
        .o_product (o_product),
        .o_rdy     (o_rdy),
        .o_state   (o_state)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    function automatic product_t ref_product(input operand_t a, input operand_t b);
        return product_t'(a) * product_t'(b);
    endfunction

    // one start pulse with the expected result queued for the comparator
    task automatic start_mult(input operand_t mcand, input operand_t mplier);
        @(posedge clk);
        #STIM_DELAY;
        i_start            = 1'b1;
        i_req.multiplicand = mcand;
        i_req.multiplier   = mplier;
        exp_q.push_back(ref_product(mcand, mplier));
        start_q.push_back(cycle_cnt + 1);   // sampled at the next edge
        issued++;
        @(posedge clk);
        #STIM_DELAY;
        i_start = 1'b0;
    endtask

    task automatic wait_result();
        wait (checked == issued);
    endtask

    task automatic run_mult(input operand_t mcand, input operand_t mplier);
        start_mult(mcand, mplier);
        wait_result();
    endtask

    // start pulse with other operands while the first run is busy
    task automatic run_with_stray_start(input operand_t mcand, input operand_t mplier,
                                        input operand_t stray_a, input operand_t stray_b);
        start_mult(mcand, mplier);
        repeat (2) @(posedge clk);
        #STIM_DELAY;
        i_start            = 1'b1;
        i_req.multiplicand = stray_a;
        i_req.multiplier   = stray_b;
        @(posedge clk);
        #STIM_DELAY;
        i_start = 1'b0;
        wait_result();
    endtask

    task automatic check_hold(input product_t exp);
        repeat (HOLD_CYCLES) begin
            @(negedge clk);
            check_product(o_product, exp, "hold in READY");
            check_rdy(o_rdy, 1'b1, "hold in READY");
            check_state(o_state, READY, "hold in READY");
        end
    endtask

    // comparator with one check per rise of o_rdy
    initial begin
        product_t exp_prod;
        int       start_cyc;
        forever begin
            @(posedge o_rdy);
            @(negedge clk);                 // outputs settled
            if (exp_q.size() == 0) begin
                $display("o_rdy rose at %0t ns with no multiplication pending", $time);
                err_timing++;
            end else begin
                exp_prod  = exp_q.pop_front();
                start_cyc = start_q.pop_front();
                check_product(o_product, exp_prod, "result");
                check_state(o_state, READY, "result");
                check_latency(cycle_cnt - start_cyc, RDY_LATENCY, "o_rdy latency");
                checked++;
            end
        end
    end

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("timeout, the tests did not finish within %0d clock cycles", TIMEOUT_CYCLES);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        logic [31:0] rnd;
        int          idx;
        rst     = 1'b0;
        i_start = 1'b0;
        i_req   = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #STIM_DELAY;
        rst = 1'b1;
        @(negedge clk);
        check_rdy(o_rdy, 1'b0, "after reset");
        check_state(o_state, IDLE, "after reset");
        check_product(o_product, '0, "after reset");

        // corner operands where the first one starts from IDLE
        run_mult(8'd0, 8'd0);
        run_mult(8'd255, 8'd255);
        run_mult(8'd1, 8'd255);
        run_mult(8'd255, 8'd1);
        run_mult(8'd128, 8'd2);
        check_state(o_state, READY, "before random runs");

        for (idx = 0; idx < N_RANDOM; idx++) begin
            rnd = $random(seed);
            run_mult(rnd[7:0], rnd[15:8]);
        end

        run_with_stray_start(8'h0f, 8'hf3, 8'h5a, 8'ha5);
        check_hold(ref_product(8'h0f, 8'hf3));
        repeat (4) @(posedge clk);

        $display("errors: product %0d, status %0d, timing %0d", err_product, err_status,
                 err_timing);
        if (err_product + err_status + err_timing == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- sources.f
+incdir+sim
verilog/definitions_pkg.sv
verilog/control_unit.sv
verilog/phase_counters.sv
verilog/shift_add_datapath.sv
verilog/seq_multiplier.sv
sim/tb_seq_multiplier.sv

//--- verilog/control_unit.sv
`timescale 1ns/10ps

module control_unit (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  i_start,
    input  logic                  i_ovf,
    input  definitions_pkg::cnt_t i_cnt,
    output logic                  o_rdy,
    output logic                  o_enb,
    output logic                  o_clr,
    output logic                  o_enb_cnt,
    output logic                  o_load,
    output definitions_pkg::state_e o_state
);

    import definitions_pkg::*;

    state_e state;
    state_e state_next;
    logic   clr_window;     // first CLR_CYCLES cycles of READY

    // state register
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    // next state
    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (i_start) begin
                    state_next = PROCESING;
                end
            end
            PROCESING: begin
                // start is not looked at here
                if (i_ovf) begin
                    state_next = READY;
                end
            end
            READY: begin
                if (i_start) begin
                    state_next = PROCESING;
                end
            end
            default: state_next = IDLE;
        endcase
    end

    assign clr_window = (i_cnt < CNT_CLR);

    // output decoder
    always_comb begin
        o_rdy     = U_ZERO;
        o_enb     = U_ZERO;
        o_clr     = U_ZERO;
        o_enb_cnt = U_ZERO;
        o_load    = U_ZERO;
        case (state)
            IDLE: begin
                o_load = i_start;   // mealy strobe captures operands on the start edge
            end
            PROCESING: begin
                o_enb = U_ONE;
            end
            READY: begin
                o_rdy     = U_ONE;
                o_load    = i_start;
                o_clr     = clr_window;     // resets the step counter
                o_enb_cnt = clr_window;
            end
            default: begin
                o_rdy = U_ZERO;
            end
        endcase
    end

    assign o_state = state;     // debug copy

endmodule

//--- verilog/definitions_pkg.sv
package definitions_pkg;

    // multiplier geometry
    localparam int OPERAND_W  = 8;
    localparam int PRODUCT_W  = 2 * OPERAND_W;
    localparam int STEPS      = 8;              // one shift-add per operand bit
    localparam int STEP_W     = $clog2(STEPS);
    localparam int CNT_W      = 4;

    // clear window length in READY in cycles
    localparam int CLR_CYCLES = 2;

    // single-bit constants for the output decoder
    localparam logic U_ZERO = 1'b0;
    localparam logic U_ONE  = 1'b1;

    typedef logic [OPERAND_W-1:0] operand_t;    // one factor
    typedef logic [PRODUCT_W-1:0] product_t;    // full-width product
    typedef logic [STEP_W-1:0]    step_t;       // step index 0..7
    typedef logic [CNT_W-1:0]     cnt_t;        // settle count

    // last step index where overflow is flagged
    localparam step_t STEP_LAST = step_t'(STEPS - 1);

    // settle count limits
    localparam cnt_t CNT_CLR = cnt_t'(CLR_CYCLES);
    localparam cnt_t CNT_MAX = '1;

    // controller states
    typedef enum logic [1:0] {
        IDLE      = 2'b00,
        PROCESING = 2'b01,
        READY     = 2'b10
    } state_e;

    // both operands of one multiplication
    typedef struct packed {
        operand_t multiplicand;
        operand_t multiplier;
    } mul_req_t;

endpackage

//--- verilog/phase_counters.sv
`timescale 1ns/10ps

module phase_counters (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  i_enb,
    input  logic                  i_clr,
    input  logic                  i_load,
    input  logic                  i_enb_cnt,
    output logic                  o_ovf,
    output definitions_pkg::cnt_t o_cnt
);

    import definitions_pkg::*;

    step_t step;    // index of the next shift-add step
    cnt_t  cnt;     // cycles spent in the clear window

    // step counter wraps back to 0 after the last step
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            step <= '0;
        end else if (i_load || i_clr) begin
            step <= '0;
        end else if (i_enb) begin
            step <= step + step_t'(1);
        end
    end

    // eighth enabled step
    assign o_ovf = i_enb && (step == STEP_LAST);

    // settle counter
    // held at its top value so the clear window cannot open again
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            cnt <= '0;
        end else if (i_load) begin
            cnt <= '0;
        end else if (i_enb_cnt && (cnt != CNT_MAX)) begin
            cnt <= cnt + cnt_t'(1);
        end
    end

    assign o_cnt = cnt;

endmodule

//--- verilog/seq_multiplier.sv
`timescale 1ns/10ps

module seq_multiplier (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      i_start,
    input  definitions_pkg::mul_req_t i_req,
    output definitions_pkg::product_t o_product,
    output logic                      o_rdy,
    output definitions_pkg::state_e   o_state
);

    import definitions_pkg::*;

    logic load;
    logic enb;
    logic clr;
    logic enb_cnt;
    logic ovf;
    cnt_t cnt;

    // sequencing
    control_unit control_unit_i (
        .clk       (clk),
        .rst       (rst),
        .i_start   (i_start),
        .i_ovf     (ovf),
        .i_cnt     (cnt),
        .o_rdy     (o_rdy),
        .o_enb     (enb),
        .o_clr     (clr),
        .o_enb_cnt (enb_cnt),
        .o_load    (load),
        .o_state   (o_state)
    );

    // step and settle counters
    phase_counters phase_counters_i (
        .clk       (clk),
        .rst       (rst),
        .i_enb     (enb),
        .i_clr     (clr),
        .i_load    (load),
        .i_enb_cnt (enb_cnt),
        .o_ovf     (ovf),
        .o_cnt     (cnt)
    );

    shift_add_datapath shift_add_datapath_i (
        .clk       (clk),
        .rst       (rst),
        .i_load    (load),
        .i_enb     (enb),
        .i_req     (i_req),
        .o_product (o_product)
    );

endmodule

//--- verilog/shift_add_datapath.sv
`timescale 1ns/10ps

module shift_add_datapath (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      i_load,
    input  logic                      i_enb,
    input  definitions_pkg::mul_req_t i_req,
    output definitions_pkg::product_t o_product
);

    import definitions_pkg::*;

    operand_t            mcand;     // multiplicand held for the whole run
    product_t            acc;       // {partial sum, remaining multiplier bits}
    operand_t            acc_hi;
    operand_t            addend;
    logic [OPERAND_W:0]  sum;       // carry kept for the shift
    product_t            acc_step;

    // operand register only written on load
    always_ff @(posedge clk) begin
        if (i_load) begin
            mcand <= i_req.multiplicand;
        end
    end

    assign acc_hi = acc[PRODUCT_W-1:OPERAND_W];

    // add multiplicand when the current multiplier bit is set
    assign addend = acc[0] ? mcand : '0;
    assign sum    = {1'b0, acc_hi} + {1'b0, addend};

    // shift right by one so the carry drops into the top bit
    assign acc_step = {sum, acc[OPERAND_W-1:1]};

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            acc <= '0;
        end else if (i_load) begin
            acc <= {{OPERAND_W{1'b0}}, i_req.multiplier};
        end else if (i_enb) begin
            acc <= acc_step;
        end
    end

    // after STEPS shifts the multiplier is gone and acc is the product
    assign o_product = acc;

endmodule
